//--- axil_csr_slave.sv
`timescale 1ns/1ps

module axil_csr_slave
  ( input  logic                                         aclk
  , input  logic                                         rst_i
  , input  zynq_shell_pkg::axil_req_s                    axil_req_i
  , output zynq_shell_pkg::axil_rsp_s                    axil_rsp_o
  , output logic                                         sys_reset_o
  , output zynq_shell_pkg::word_t                        req_word_o
  , output logic                                         req_word_v_o
  , input  logic                                         req_word_yumi_i
  , input  zynq_shell_pkg::word_t                        rsp_word_i
  , input  logic                                         rsp_word_v_i
  , output logic                                         rsp_word_ready_o
  , input  logic [zynq_shell_pkg::credit_width_lp-1:0]   credits_used_i
  );

  import zynq_shell_pkg::*;

  logic                            wr_hs;
  logic                            wr_en;
  logic                            rd_hs;
  logic                            bvalid_r;
  logic                            rvalid_r;
  word_t                           rdata_r;
  word_t                           rdata_n;
  logic                            run_r;
  logic [reset_depth_lp-1:0]       reset_chain_r;

  logic                            req_push;
  logic                            req_fifo_ready;
  logic [word_count_width_lp-1:0]  req_count;
  logic                            rsp_pop;
  word_t                           rsp_fifo_data;
  logic                            rsp_fifo_v;
  logic [word_count_width_lp-1:0]  rsp_count;

  ////////////////////////////////////////////////////////////////////////////
  // write channel
  ////////////////////////////////////////////////////////////////////////////

  // address and data taken together, one outstanding response
  assign wr_hs = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_r;
  assign wr_en = wr_hs & (|axil_req_i.wstrb);

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      bvalid_r <= 1'b0;
    end
    else if (wr_hs)
    begin
      bvalid_r <= 1'b1;
    end
    else if (axil_req_i.bready)
    begin
      bvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      run_r <= 1'b0;
    end
    else if (wr_en && axil_req_i.wstrb[0] && axil_req_i.awaddr == csr_ctrl_addr_lp)
    begin
      run_r <= axil_req_i.wdata[0];
    end
  end

  // a full window drops the word
  assign req_push = wr_en & req_fifo_ready & (axil_req_i.awaddr == csr_req_data_addr_lp);

  ////////////////////////////////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////////////////////////////////

  assign rd_hs   = axil_req_i.arvalid & ~rvalid_r;
  assign rsp_pop = rd_hs & rsp_fifo_v & (axil_req_i.araddr == csr_rsp_data_addr_lp);

  always_comb
  begin
    rdata_n = '0;
    case (axil_req_i.araddr)
      csr_ctrl_addr_lp:      rdata_n = word_t'(run_r);
      csr_credits_addr_lp:   rdata_n = word_t'(credits_used_i);
      csr_rsp_data_addr_lp:  rdata_n = rsp_fifo_v ? rsp_fifo_data : '0;
      csr_rsp_count_addr_lp: rdata_n = word_t'(rsp_count);
      csr_req_free_addr_lp:  rdata_n = word_t'(word_fifo_els_lp) - word_t'(req_count);
      default:               rdata_n = '0;
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      rvalid_r <= 1'b0;
    end
    else if (rd_hs)
    begin
      rvalid_r <= 1'b1;
    end
    else if (axil_req_i.rready)
    begin
      rvalid_r <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rd_hs)
    begin
      rdata_r <= rdata_n;
    end
  end

  assign axil_rsp_o.awready = wr_hs;
  assign axil_rsp_o.wready  = wr_hs;
  assign axil_rsp_o.bresp   = axil_resp_okay_lp;
  assign axil_rsp_o.bvalid  = bvalid_r;
  assign axil_rsp_o.arready = ~rvalid_r;
  assign axil_rsp_o.rdata   = rdata_r;
  assign axil_rsp_o.rresp   = axil_resp_okay_lp;
  assign axil_rsp_o.rvalid  = rvalid_r;

  ////////////////////////////////////////////////////////////////////////////
  // system reset, held while run is low
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      reset_chain_r <= '1;
    end
    else
    begin
      reset_chain_r <= {reset_chain_r[reset_depth_lp-2:0], ~run_r};
    end
  end

  assign sys_reset_o = reset_chain_r[reset_depth_lp-1];

  // word windows live on rst_i only
  host_fifo #(.data_t(word_t), .els_p(word_fifo_els_lp)) i_req_fifo
    ( .aclk    (aclk)
    , .rst_i   (rst_i)
    , .data_i  (axil_req_i.wdata)
    , .v_i     (req_push)
    , .ready_o (req_fifo_ready)
    , .data_o  (req_word_o)
    , .v_o     (req_word_v_o)
    , .yumi_i  (req_word_yumi_i)
    , .count_o (req_count)
    );

  host_fifo #(.data_t(word_t), .els_p(word_fifo_els_lp)) i_rsp_fifo
    ( .aclk    (aclk)
    , .rst_i   (rst_i)
    , .data_i  (rsp_word_i)
    , .v_i     (rsp_word_v_i)
    , .ready_o (rsp_word_ready_o)
    , .data_o  (rsp_fifo_data)
    , .v_o     (rsp_fifo_v)
    , .yumi_i  (rsp_pop)
    , .count_o (rsp_count)
    );

endmodule

//--- flist.f
zynq_shell_pkg.sv
host_fifo.sv
axil_csr_slave.sv
host_packet_bridge.sv
scratchpad_ep.sv
zynq_host_top.sv
zynq_host_top_sva.sv
tb_zynq_host_top.sv

//--- host_fifo.sv
`timescale 1ns/1ps

module host_fifo
  #(parameter type data_t = zynq_shell_pkg::word_t
  , parameter int els_p   = zynq_shell_pkg::word_fifo_els_lp
  )
  ( input  logic                         aclk
  , input  logic                         rst_i
  , input  data_t                        data_i
  , input  logic                         v_i
  , output logic                         ready_o
  , output data_t                        data_o
  , output logic                         v_o
  , input  logic                         yumi_i
  , output logic [$clog2(els_p+1)-1:0]   count_o
  );

  data_t                        mem_r [els_p];
  logic [$clog2(els_p)-1:0]     wr_ptr_r;
  logic [$clog2(els_p)-1:0]     rd_ptr_r;
  logic [$clog2(els_p+1)-1:0]   count_r;
  logic                         push;
  logic                         pop;

  assign ready_o = (count_r != ($clog2(els_p+1))'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];
  assign count_o = count_r;

  // full drops the push, empty ignores yumi
  assign push = v_i & ready_o;
  assign pop  = yumi_i & v_o;

  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_r <= (wr_ptr_r == ($clog2(els_p))'(els_p-1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_r <= (rd_ptr_r == ($clog2(els_p))'(els_p-1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

//--- host_packet_bridge.sv
`timescale 1ns/1ps

module host_packet_bridge
  ( input  logic                                         aclk
  , input  logic                                         rst_i
  , input  zynq_shell_pkg::word_t                        req_word_i
  , input  logic                                         req_word_v_i
  , output logic                                         req_word_yumi_o
  , output zynq_shell_pkg::word_t                        rsp_word_o
  , output logic                                         rsp_word_v_o
  , input  logic                                         rsp_word_ready_i
  , output zynq_shell_pkg::ep_pkt_s                      req_pkt_o
  , output logic                                         req_v_o
  , input  logic                                         credit_i
  , input  zynq_shell_pkg::ep_pkt_s                      rsp_pkt_i
  , input  logic                                         rsp_v_i
  , output logic                                         rsp_ready_o
  , output logic [zynq_shell_pkg::credit_width_lp-1:0]   credits_used_o
  );

  import zynq_shell_pkg::*;

  ep_pkt_s                         gather_pkt_r;
  logic [$clog2(pkt_words_lp)-1:0] gather_cnt_r;
  logic                            gather_full_r;
  logic                            req_send;
  logic [credit_width_lp-1:0]      credits_used_r;

  ep_pkt_s                         scatter_pkt_r;
  logic [$clog2(pkt_words_lp)-1:0] scatter_cnt_r;
  logic                            scatter_full_r;
  logic                            rsp_load;
  logic                            rsp_word_take;

  ////////////////////////////////////////////////////////////////////////////
  // gather and credited issue
  ////////////////////////////////////////////////////////////////////////////

  // words wait in the window while held in reset
  assign req_word_yumi_o = req_word_v_i & ~gather_full_r & ~rst_i;
  assign req_v_o         = gather_full_r & (credits_used_r < credit_width_lp'(max_credits_lp));
  assign req_send        = req_v_o;
  assign req_pkt_o       = gather_pkt_r;
  assign credits_used_o  = credits_used_r;

  // shift in from the bottom, oldest word ends up in opcode
  always_ff @(posedge aclk)
  begin
    if (req_word_yumi_o)
    begin
      gather_pkt_r <= {gather_pkt_r[(pkt_words_lp-1)*axil_data_width_lp-1:0], req_word_i};
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      gather_cnt_r  <= '0;
      gather_full_r <= 1'b0;
    end
    else if (req_word_yumi_o)
    begin
      gather_cnt_r <= gather_cnt_r + 1'b1;
      if (gather_cnt_r == ($clog2(pkt_words_lp))'(pkt_words_lp-1))
      begin
        gather_full_r <= 1'b1;
      end
    end
    else if (req_send)
    begin
      gather_full_r <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      credits_used_r <= '0;
    end
    else
    begin
      case ({req_send, credit_i})
        2'b10:   credits_used_r <= credits_used_r + 1'b1;
        2'b01:   credits_used_r <= credits_used_r - 1'b1;
        default: credits_used_r <= credits_used_r;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // scatter
  ////////////////////////////////////////////////////////////////////////////

  assign rsp_ready_o   = ~scatter_full_r;
  assign rsp_load      = rsp_v_i & rsp_ready_o;
  assign rsp_word_v_o  = scatter_full_r;
  assign rsp_word_take = rsp_word_v_o & rsp_word_ready_i;

  always_ff @(posedge aclk)
  begin
    if (rsp_load)
    begin
      scatter_pkt_r <= rsp_pkt_i;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      scatter_cnt_r  <= '0;
      scatter_full_r <= 1'b0;
    end
    else if (rsp_load)
    begin
      scatter_cnt_r  <= '0;
      scatter_full_r <= 1'b1;
    end
    else if (rsp_word_take)
    begin
      scatter_cnt_r <= scatter_cnt_r + 1'b1;
      if (scatter_cnt_r == ($clog2(pkt_words_lp))'(pkt_words_lp-1))
      begin
        scatter_full_r <= 1'b0;
      end
    end
  end

  // field order matches the gather side
  always_comb
  begin
    case (scatter_cnt_r)
      2'd0:    rsp_word_o = scatter_pkt_r.opcode;
      2'd1:    rsp_word_o = scatter_pkt_r.addr;
      2'd2:    rsp_word_o = scatter_pkt_r.data;
      default: rsp_word_o = scatter_pkt_r.tag;
    endcase
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -sv --top-module tb_zynq_host_top -f flist.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log
if grep -q "Simulation failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "FAIL: run ended without a result"
  exit 1
fi
echo "PASS"

//--- scratchpad_ep.sv
`timescale 1ns/1ps

module scratchpad_ep
  ( input  logic                     aclk
  , input  logic                     rst_i
  , input  zynq_shell_pkg::ep_pkt_s  req_pkt_i
  , input  logic                     req_v_i
  , output logic                     credit_o
  , output zynq_shell_pkg::ep_pkt_s  rsp_pkt_o
  , output logic                     rsp_v_o
  , input  logic                     rsp_ready_i
  );

  import zynq_shell_pkg::*;

  ep_pkt_s                      q_pkt;
  logic                         q_v;
  logic                         pop;
  logic                         is_write;
  logic [sp_addr_width_lp-1:0]  sp_addr;
  word_t                        sp_mem_r [sp_words_lp];
  ep_pkt_s                      rsp_pkt_r;
  logic                         rsp_v_r;

  // sender holds a credit per entry, so the queue never overflows
  host_fifo #(.data_t(ep_pkt_s), .els_p(max_credits_lp)) i_req_queue
    ( .aclk    (aclk)
    , .rst_i   (rst_i)
    , .data_i  (req_pkt_i)
    , .v_i     (req_v_i)
    , .ready_o ()
    , .data_o  (q_pkt)
    , .v_o     (q_v)
    , .yumi_i  (pop)
    , .count_o ()
    );

  assign pop      = q_v & (~rsp_v_r | rsp_ready_i);
  assign credit_o = pop;
  assign is_write = (opcode_e'(q_pkt.opcode[1:0]) == op_write);
  assign sp_addr  = q_pkt.addr[sp_addr_width_lp-1:0];

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < sp_words_lp; i++)
      begin
        sp_mem_r[i] <= '0;
      end
    end
    else if (pop && is_write)
    begin
      sp_mem_r[sp_addr] <= q_pkt.data;
    end
  end

  // read returns stored word, write echoes
  always_ff @(posedge aclk)
  begin
    if (pop)
    begin
      rsp_pkt_r      <= q_pkt;
      rsp_pkt_r.data <= is_write ? q_pkt.data : sp_mem_r[sp_addr];
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      rsp_v_r <= 1'b0;
    end
    else if (pop)
    begin
      rsp_v_r <= 1'b1;
    end
    else if (rsp_ready_i)
    begin
      rsp_v_r <= 1'b0;
    end
  end

  assign rsp_pkt_o = rsp_pkt_r;
  assign rsp_v_o   = rsp_v_r;

endmodule

//--- tb_zynq_host_top.sv
`timescale 1ns/1ps

module tb_zynq_host_top;

  import zynq_shell_pkg::*;

  localparam int wait_limit_lp  = 400;
  localparam int quiet_polls_lp = 12;
  localparam int random_pkts_lp = 20;
  // rsp window, scatter, endpoint hold, gather, queue, req window
  localparam int backlog_pkts_lp = 2 * (word_fifo_els_lp / pkt_words_lp) + 3 + max_credits_lp;

  logic        aclk = 1'b0;
  logic        rst_i;
  axil_req_s   axil_req;
  axil_rsp_s   axil_rsp;
  logic [15:0] lfsr_r;
  word_t       ref_mem [sp_words_lp];
  ep_pkt_s     pending_q [$];

  zynq_host_top i_zynq_host_top
    ( .aclk       (aclk)
    , .rst_i      (rst_i)
    , .axil_req_i (axil_req)
    , .axil_rsp_o (axil_rsp)
    );

  always #50 aclk = ~aclk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // taps 16 14 13 11
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_r[15] ^ lfsr_r[13] ^ lfsr_r[12] ^ lfsr_r[10];
    lfsr_r = {lfsr_r[14:0], fb};
    return fb;
  endfunction

  function automatic word_t lfsr_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[axil_data_width_lp-2:0], lfsr_step()};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected)
    begin
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    $display("Simulation failed");
    $fatal(1, "wait limit reached");
  endtask

  task automatic axil_write(input logic [axil_addr_width_lp-1:0] addr, input word_t data);
    int n;
    @(posedge aclk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= '1;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= 1'b1;
    n = 0;
    @(negedge aclk);
    while (!axil_rsp.awready && n < wait_limit_lp)
    begin
      @(negedge aclk);
      n++;
    end
    if (!axil_rsp.awready)
    begin
      timeout_fail("write address accept");
    end
    check_value("wready", word_t'(axil_rsp.wready), 32'd1);
    @(posedge aclk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    n = 0;
    @(negedge aclk);
    while (!axil_rsp.bvalid && n < wait_limit_lp)
    begin
      @(negedge aclk);
      n++;
    end
    if (!axil_rsp.bvalid)
    begin
      timeout_fail("write response");
    end
    check_value("bresp", word_t'(axil_rsp.bresp), word_t'(axil_resp_okay_lp));
    @(posedge aclk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [axil_addr_width_lp-1:0] addr, output word_t data);
    int n;
    @(posedge aclk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= 1'b1;
    n = 0;
    @(negedge aclk);
    while (!axil_rsp.arready && n < wait_limit_lp)
    begin
      @(negedge aclk);
      n++;
    end
    if (!axil_rsp.arready)
    begin
      timeout_fail("read address accept");
    end
    @(posedge aclk);
    axil_req.arvalid <= 1'b0;
    n = 0;
    @(negedge aclk);
    while (!axil_rsp.rvalid && n < wait_limit_lp)
    begin
      @(negedge aclk);
      n++;
    end
    if (!axil_rsp.rvalid)
    begin
      timeout_fail("read data");
    end
    data = axil_rsp.rdata;
    check_value("rresp", word_t'(axil_rsp.rresp), word_t'(axil_resp_okay_lp));
    @(posedge aclk);
    axil_req.rready <= 1'b0;
  endtask

  task automatic read_check(input logic [axil_addr_width_lp-1:0] addr, input word_t expected,
                            input string name);
    word_t v;
    axil_read(addr, v);
    check_value(name, v, expected);
  endtask

  // at_least selects >= instead of ==
  task automatic poll_reg(input logic [axil_addr_width_lp-1:0] addr, input word_t target,
                          input logic at_least, input string name);
    word_t v;
    int    n;
    n = 0;
    axil_read(addr, v);
    while (!(at_least ? v >= target : v == target) && n < wait_limit_lp)
    begin
      axil_read(addr, v);
      n++;
    end
    if (!(at_least ? v >= target : v == target))
    begin
      timeout_fail(name);
    end
  endtask

  function automatic ep_pkt_s make_packet(input word_t op, input word_t addr,
                                          input word_t data, input word_t tag);
    ep_pkt_s p;
    p.opcode = op;
    p.addr   = addr;
    p.data   = data;
    p.tag    = tag;
    return p;
  endfunction

  // scratchpad model, word index is the low address bits
  function automatic ep_pkt_s model_response(input ep_pkt_s req);
    ep_pkt_s                     rsp;
    logic [sp_addr_width_lp-1:0] a;
    rsp = req;
    a   = req.addr[sp_addr_width_lp-1:0];
    if (req.opcode == word_t'(op_write))
    begin
      ref_mem[a] = req.data;
    end
    else
    begin
      rsp.data = ref_mem[a];
    end
    return rsp;
  endfunction

  task automatic send_packet(input ep_pkt_s p);
    axil_write(csr_req_data_addr_lp, p.opcode);
    axil_write(csr_req_data_addr_lp, p.addr);
    axil_write(csr_req_data_addr_lp, p.data);
    axil_write(csr_req_data_addr_lp, p.tag);
  endtask

  task automatic recv_packet(input ep_pkt_s expected);
    poll_reg(csr_rsp_count_addr_lp, word_t'(pkt_words_lp), 1'b1, "response words");
    read_check(csr_rsp_data_addr_lp, expected.opcode, "rsp opcode");
    read_check(csr_rsp_data_addr_lp, expected.addr, "rsp addr");
    read_check(csr_rsp_data_addr_lp, expected.data, "rsp data");
    read_check(csr_rsp_data_addr_lp, expected.tag, "rsp tag");
  endtask

  task automatic run_packet(input ep_pkt_s p);
    send_packet(p);
    recv_packet(model_response(p));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    read_check(csr_ctrl_addr_lp, '0, "ctrl");
    read_check(csr_credits_addr_lp, '0, "credits_used");
    read_check(csr_rsp_count_addr_lp, '0, "rsp_count");
    read_check(csr_req_free_addr_lp, word_t'(word_fifo_els_lp), "req_free");
    read_check(10'h030, '0, "unmapped");
    read_check(csr_rsp_data_addr_lp, '0, "rsp_data empty");
  endtask

  task automatic test_run_control();
    ep_pkt_s p;
    p = make_packet(op_write, 32'd5, 32'hCAFE_0005, 32'h0000_0001);
    axil_write(csr_ctrl_addr_lp, 32'hFFFF_FFFE);
    read_check(csr_ctrl_addr_lp, '0, "ctrl");
    send_packet(p);
    read_check(csr_req_free_addr_lp, word_t'(word_fifo_els_lp - pkt_words_lp),
               "req_free while held");
    // bridge and endpoint held, nothing comes back
    for (int i = 0; i < quiet_polls_lp; i++)
    begin
      read_check(csr_rsp_count_addr_lp, '0, "rsp_count while held");
    end
    axil_write(csr_ctrl_addr_lp, 32'h1);
    read_check(csr_ctrl_addr_lp, 32'h1, "ctrl");
    recv_packet(model_response(p));
    read_check(csr_req_free_addr_lp, word_t'(word_fifo_els_lp), "req_free");
    read_check(csr_credits_addr_lp, '0, "credits_used");
  endtask

  task automatic test_write_then_read();
    run_packet(make_packet(op_write, 32'd9, 32'h5A5A_1234, 32'h0000_0010));
    run_packet(make_packet(op_read, 32'd9, 32'h0, 32'h0000_0011));
  endtask

  task automatic test_random_packets();
    for (int i = 0; i < random_pkts_lp; i++)
    begin
      run_packet(make_packet(lfsr_bits(1), lfsr_bits(8), lfsr_bits(32),
                             32'h100 + word_t'(i)));
    end
  endtask

  task automatic test_backpressure();
    ep_pkt_s p;
    for (int i = 0; i < backlog_pkts_lp; i++)
    begin
      poll_reg(csr_req_free_addr_lp, word_t'(pkt_words_lp), 1'b1, "request space");
      p = make_packet(op_read, lfsr_bits(6), '0, 32'h200 + word_t'(i));
      pending_q.push_back(model_response(p));
      send_packet(p);
    end
    poll_reg(csr_req_free_addr_lp, '0, 1'b0, "request window to fill");
    // queue full, every credit out
    read_check(csr_credits_addr_lp, word_t'(max_credits_lp), "credits_used at backlog");
    while (pending_q.size() > 0)
    begin
      recv_packet(pending_q.pop_front());
    end
    read_check(csr_credits_addr_lp, '0, "credits_used");
  endtask

  initial
  begin
    lfsr_r   = 16'd64785;
    rst_i    = 1'b1;
    axil_req = '0;
    for (int i = 0; i < sp_words_lp; i++)
    begin
      ref_mem[i] = '0;
    end
    repeat (8) @(posedge aclk);
    rst_i <= 1'b0;
    test_reset_values();
    test_run_control();
    test_write_then_read();
    test_random_packets();
    test_backpressure();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- zynq_host_top.sv
`timescale 1ns/1ps

module zynq_host_top
  ( input  logic                       aclk
  , input  logic                       rst_i
  , input  zynq_shell_pkg::axil_req_s  axil_req_i
  , output zynq_shell_pkg::axil_rsp_s  axil_rsp_o
  );

  import zynq_shell_pkg::*;

  logic                        sys_reset;
  word_t                       req_word;
  logic                        req_word_v;
  logic                        req_word_yumi;
  word_t                       rsp_word;
  logic                        rsp_word_v;
  logic                        rsp_word_ready;
  logic [credit_width_lp-1:0]  credits_used;
  ep_pkt_s                     req_pkt;
  logic                        req_v;
  logic                        credit;
  ep_pkt_s                     rsp_pkt;
  logic                        rsp_v;
  logic                        rsp_ready;

  axil_csr_slave i_axil_csr_slave
    ( .aclk             (aclk)
    , .rst_i            (rst_i)
    , .axil_req_i       (axil_req_i)
    , .axil_rsp_o       (axil_rsp_o)
    , .sys_reset_o      (sys_reset)
    , .req_word_o       (req_word)
    , .req_word_v_o     (req_word_v)
    , .req_word_yumi_i  (req_word_yumi)
    , .rsp_word_i       (rsp_word)
    , .rsp_word_v_i     (rsp_word_v)
    , .rsp_word_ready_o (rsp_word_ready)
    , .credits_used_i   (credits_used)
    );

  host_packet_bridge i_host_packet_bridge
    ( .aclk             (aclk)
    , .rst_i            (sys_reset)
    , .req_word_i       (req_word)
    , .req_word_v_i     (req_word_v)
    , .req_word_yumi_o  (req_word_yumi)
    , .rsp_word_o       (rsp_word)
    , .rsp_word_v_o     (rsp_word_v)
    , .rsp_word_ready_i (rsp_word_ready)
    , .req_pkt_o        (req_pkt)
    , .req_v_o          (req_v)
    , .credit_i         (credit)
    , .rsp_pkt_i        (rsp_pkt)
    , .rsp_v_i          (rsp_v)
    , .rsp_ready_o      (rsp_ready)
    , .credits_used_o   (credits_used)
    );

  scratchpad_ep i_scratchpad_ep
    ( .aclk        (aclk)
    , .rst_i       (sys_reset)
    , .req_pkt_i   (req_pkt)
    , .req_v_i     (req_v)
    , .credit_o    (credit)
    , .rsp_pkt_o   (rsp_pkt)
    , .rsp_v_o     (rsp_v)
    , .rsp_ready_i (rsp_ready)
    );

endmodule

//--- zynq_host_top_sva.sv
`timescale 1ns/1ps

module zynq_host_top_sva
  ( input  logic                                        aclk
  , input  logic                                        rst_i
  , input  zynq_shell_pkg::axil_req_s                   axil_req_i
  , input  zynq_shell_pkg::axil_rsp_s                   axil_rsp_i
  , input  logic [zynq_shell_pkg::credit_width_lp-1:0]  credits_used_i
  );

  import zynq_shell_pkg::*;

  // bridge credit count, seen at the slave
  credits_bounded: assert property (@(posedge aclk) disable iff (rst_i)
    credits_used_i <= credit_width_lp'(max_credits_lp))
    else $error("credits used above the endpoint queue depth");

  bresp_okay: assert property (@(posedge aclk) disable iff (rst_i)
    axil_rsp_i.bvalid |-> axil_rsp_i.bresp == axil_resp_okay_lp)
    else $error("bresp not OKAY");

  rresp_okay: assert property (@(posedge aclk) disable iff (rst_i)
    axil_rsp_i.rvalid |-> axil_rsp_i.rresp == axil_resp_okay_lp)
    else $error("rresp not OKAY");

  bvalid_held: assert property (@(posedge aclk) disable iff (rst_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
    else $error("bvalid dropped before bready");

endmodule

bind axil_csr_slave zynq_host_top_sva i_zynq_host_top_sva
  ( .aclk           (aclk)
  , .rst_i          (rst_i)
  , .axil_req_i     (axil_req_i)
  , .axil_rsp_i     (axil_rsp_o)
  , .credits_used_i (credits_used_i)
  );

//--- zynq_shell_pkg.sv
package zynq_shell_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and depths
  ////////////////////////////////////////////////////////////////////////////

  localparam int axil_data_width_lp  = 32;
  localparam int axil_addr_width_lp  = 10;
  localparam int pkt_words_lp        = 4;
  localparam int word_fifo_els_lp    = 8;
  localparam int word_count_width_lp = $clog2(word_fifo_els_lp + 1);
  localparam int max_credits_lp      = 4;
  localparam int credit_width_lp     = 3;
  localparam int reset_depth_lp      = 3;
  localparam int sp_words_lp         = 64;
  localparam int sp_addr_width_lp    = 6;

  ////////////////////////////////////////////////////////////////////////////
  // register map, byte offsets
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [axil_addr_width_lp-1:0] csr_ctrl_addr_lp      = 10'h000;
  localparam logic [axil_addr_width_lp-1:0] csr_credits_addr_lp   = 10'h008;
  localparam logic [axil_addr_width_lp-1:0] csr_req_data_addr_lp  = 10'h010;
  localparam logic [axil_addr_width_lp-1:0] csr_rsp_data_addr_lp  = 10'h014;
  localparam logic [axil_addr_width_lp-1:0] csr_rsp_count_addr_lp = 10'h018;
  localparam logic [axil_addr_width_lp-1:0] csr_req_free_addr_lp  = 10'h01C;

  localparam logic [1:0] axil_resp_okay_lp = 2'b00;

  typedef logic [axil_data_width_lp-1:0] word_t;

  typedef enum logic [1:0] {
    op_write = 2'd0,
    op_read  = 2'd1
  } opcode_e;

  // first host word lands in opcode
  typedef struct packed {
    word_t opcode;
    word_t addr;
    word_t data;
    word_t tag;
  } ep_pkt_s;

  typedef struct packed {
    logic [axil_addr_width_lp-1:0] awaddr;
    logic                          awvalid;
    word_t                         wdata;
    logic [axil_data_width_lp/8-1:0] wstrb;
    logic                          wvalid;
    logic                          bready;
    logic [axil_addr_width_lp-1:0] araddr;
    logic                          arvalid;
    logic                          rready;
  } axil_req_s;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       arready;
    word_t      rdata;
    logic [1:0] rresp;
    logic       rvalid;
  } axil_rsp_s;

endpackage
